// File: Makefile
# Verilator simulation of the posit8 dot-product unit

TOP = posit_dot2_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f posit_dot2.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// File: dv/posit_model.svh
/*
   Real-valued posit8 (es = 2) model, included inside the testbench module.
   Encoding rounds the posit bit string to nearest even and saturates at minpos and maxpos.
*/
`ifndef POSIT_MODEL_SVH
`define POSIT_MODEL_SVH

function automatic real pow2(input int e);
    real r;
    r = 1.0;
    for (int i = 0; i < ((e < 0) ? -e : e); i++)
        r = (e < 0) ? r / 2.0 : r * 2.0;
    return r;
endfunction

// Zero and NaR both map to 0.0, callers test NaR themselves
function automatic real posit_to_real(input logic [7:0] p);
    logic [7:0] mag;
    int k;
    int pos;
    int expo;
    real frac;
    real weight;
    if (p == 8'h00 || p == 8'h80)
        return 0.0;
    mag = p[7] ? 8'(-p) : p;
    pos = 6;
    k = mag[6] ? -1 : 0;
    while (pos >= 0 && mag[pos] == mag[6])
    begin
        k = mag[6] ? k + 1 : k - 1;
        pos--;
    end
    // Skip the bit that ends the regime
    pos--;
    expo = 0;
    for (int i = 0; i < 2; i++)
    begin
        expo = expo * 2;
        if (pos >= 0)
        begin
            expo = expo + int'(mag[pos]);
            pos--;
        end
    end
    frac = 1.0;
    weight = 0.5;
    while (pos >= 0)
    begin
        if (mag[pos])
            frac = frac + weight;
        weight = weight / 2.0;
        pos--;
    end
    return (p[7] ? -frac : frac) * pow2(4 * k + expo);
endfunction

function automatic logic [7:0] posit_from_real(input real v);
    real m;
    int e;
    int k;
    int ex;
    bit str[$];
    logic [6:0] body;
    bit sticky;
    if (v == 0.0)
        return 8'h00;
    m = (v < 0.0) ? -v : v;
    e = 0;
    while (m >= 2.0)
    begin
        m = m / 2.0;
        e++;
    end
    while (m < 1.0)
    begin
        m = m * 2.0;
        e--;
    end
    if (e >= 24)
        body = 7'h7F;
    else if (e < -24)
        body = 7'h01;
    else
    begin
        // Floor division by four, useed = 16
        k = e >>> 2;
        ex = e - 4 * k;
        repeat ((k >= 0) ? k + 1 : -k)
            str.push_back(k >= 0);
        str.push_back(k < 0);
        str.push_back(ex[1]);
        str.push_back(ex[0]);
        m = m - 1.0;
        repeat (48)
        begin
            m = m * 2.0;
            str.push_back(m >= 1.0);
            if (m >= 1.0)
                m = m - 1.0;
        end
        body = '0;
        for (int i = 0; i < 7; i++)
            body = {body[5:0], str[i]};
        sticky = (m != 0.0);
        for (int i = 8; i < str.size(); i++)
            sticky = sticky | str[i];
        // Guard bit sits right after the kept seven bits
        if (str[7] && (sticky || body[0]))
            body = body + 7'd1;
    end
    return (v < 0.0) ? 8'(-{1'b0, body}) : {1'b0, body};
endfunction

`endif

// File: dv/posit_dot2_tb.sv
/*
   Directed and seeded random tests of posit_dot2. Operations are compared in issue
   order and each result must arrive exactly 11 cycles after its start.
*/
`timescale 1ns/1ps
`default_nettype none

module posit_dot2_tb;

    logic clk;
    logic rst_n;
    logic start;
    logic [7:0] a, b, c, d;
    logic [7:0] result;
    logic done;

    logic [7:0] expected_q[$];
    logic [31:0] operands_q[$];
    int issue_q[$];
    int cycle;
    int errors;
    int checks;

    `include "posit_model.svh"

    posit_dot2 i_posit_dot2 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .a      (a),
        .b      (b),
        .c      (c),
        .d      (d),
        .result (result),
        .done   (done)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic compare_result();
        logic [7:0] expected;
        logic [31:0] ops;
        int issued;
        expected = expected_q.pop_front();
        ops = operands_q.pop_front();
        issued = issue_q.pop_front();
        checks++;
        if (result !== expected)
        begin
            $display("FAILED %0t: a=%h b=%h c=%h d=%h gave %h, expected %h", $time,
                     ops[31:24], ops[23:16], ops[15:8], ops[7:0], result, expected);
            errors++;
        end
        if (cycle - issued != 11)
        begin
            $display("FAILED %0t: result after %0d cycles, expected 11", $time, cycle - issued);
            errors++;
        end
    endtask

    // Outputs are stable on the falling edge
    always @(negedge clk)
    begin
        if (rst_n && done)
        begin
            if (expected_q.size() == 0)
            begin
                $display("done went high at %0t with no operation pending", $time);
                errors++;
            end
            else
                compare_result();
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        start = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic issue_operation(input logic [7:0] op_a, op_b, op_c, op_d, expected);
        @(posedge clk);
        #1;
        start = 1'b1;
        a = op_a;
        b = op_b;
        c = op_c;
        d = op_d;
        expected_q.push_back(expected);
        operands_q.push_back({op_a, op_b, op_c, op_d});
        issue_q.push_back(cycle);
    endtask

    task automatic issue_modeled(input logic [7:0] op_a, op_b, op_c, op_d);
        real exact;
        exact = posit_to_real(op_a) * posit_to_real(op_b)
              + posit_to_real(op_c) * posit_to_real(op_d);
        issue_operation(op_a, op_b, op_c, op_d, posit_from_real(exact));
    endtask

    task automatic wait_for_results();
        int waited;
        @(posedge clk);
        #1;
        start = 1'b0;
        waited = 0;
        while (expected_q.size() != 0 && waited < 50)
        begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0)
        begin
            errors++;
            $display("Timeout: %0d results did not arrive within 50 cycles", expected_q.size());
            $display("ERRORS FOUND");
            $finish;
        end
    endtask

    // Any posit except zero and NaR
    function automatic logic [7:0] random_posit();
        logic [7:0] p;
        p = 8'($urandom);
        if (p == 8'h00 || p == 8'h80)
            p = 8'h40;
        return p;
    endfunction

    // Magnitude in [2^-6, 2^7), so the scale lies in -6..6
    function automatic logic [7:0] random_bounded_posit();
        logic [7:0] p;
        logic [7:0] cand;
        real mag;
        bit found;
        p = 8'h40;
        found = 1'b0;
        for (int tries = 0; tries < 100 && !found; tries++)
        begin
            cand = random_posit();
            mag = posit_to_real(cand);
            mag = (mag < 0.0) ? -mag : mag;
            if (mag >= 1.0 / 64.0 && mag < 128.0)
            begin
                p = cand;
                found = 1'b1;
            end
        end
        return p;
    endfunction

    task automatic test_identity();
        for (int x = 0; x < 256; x++)
        begin
            if (x != 128)
                issue_operation(8'(x), 8'h40, 8'h00, random_posit(), 8'(x));
        end
        wait_for_results();
    endtask

    task automatic test_special_values();
        logic [7:0] ops [4];
        for (int pos = 0; pos < 4; pos++)
        begin
            for (int i = 0; i < 5; i++)
            begin
                for (int j = 0; j < 4; j++)
                    ops[j] = random_posit();
                ops[pos] = 8'h80;
                issue_operation(ops[0], ops[1], ops[2], ops[3], 8'h80);
            end
        end
        // NaR times zero stays NaR
        issue_operation(8'h80, 8'h00, 8'h00, 8'h00, 8'h80);
        for (int i = 0; i < 20; i++)
        begin
            for (int j = 0; j < 4; j++)
                ops[j] = random_posit();
            ops[i % 2] = 8'h00;
            ops[2 + (i / 2) % 2] = 8'h00;
            issue_operation(ops[0], ops[1], ops[2], ops[3], 8'h00);
        end
        wait_for_results();
    endtask

    task automatic test_cancellation();
        logic [7:0] ra, rb;
        for (int i = 0; i < 40; i++)
        begin
            ra = random_posit();
            rb = random_posit();
            issue_operation(ra, rb, 8'(-ra), rb, 8'h00);
        end
        wait_for_results();
    endtask

    task automatic test_directed_sums();
        logic [31:0] table_ops [8];
        table_ops[0] = {8'h44, 8'h40, 8'h44, 8'h40};  // 1.5 + 1.5 carries into [2,4)
        table_ops[1] = {8'h41, 8'h40, 8'hC0, 8'h40};  // 1.125 - 1 needs a 3-bit left shift
        table_ops[2] = {8'h48, 8'h48, 8'h38, 8'h38};
        table_ops[3] = {8'h60, 8'h40, 8'hC0, 8'h40};
        table_ops[4] = {8'h7F, 8'h7F, 8'h40, 8'h40};  // saturates at maxpos
        table_ops[5] = {8'h01, 8'h01, 8'h00, 8'h00};  // stays at minpos
        table_ops[6] = {8'h47, 8'h47, 8'hC1, 8'h40};
        table_ops[7] = {8'h3F, 8'h44, 8'h41, 8'h3C};
        for (int i = 0; i < 8; i++)
            issue_modeled(table_ops[i][31:24], table_ops[i][23:16], table_ops[i][15:8],
                          table_ops[i][7:0]);
        wait_for_results();
    endtask

    task automatic issue_same_sign_random(input int count);
        logic [7:0] ra, rb, rc, rd;
        for (int i = 0; i < count; i++)
        begin
            ra = random_bounded_posit();
            rb = random_bounded_posit();
            rc = random_bounded_posit();
            rd = random_bounded_posit();
            // Give both products the same sign
            if ((ra[7] ^ rb[7]) != (rc[7] ^ rd[7]))
                rd = 8'(-rd);
            issue_modeled(ra, rb, rc, rd);
        end
    endtask

    task automatic test_random_same_sign();
        issue_same_sign_random(300);
        wait_for_results();
    endtask

    task automatic test_throughput();
        // Operations still in flight must be dropped by reset
        for (int i = 0; i < 4; i++)
        begin
            @(posedge clk);
            #1;
            start = 1'b1;
            a = random_posit();
            b = random_posit();
            c = random_posit();
            d = random_posit();
        end
        apply_reset();
        for (int i = 0; i < 12; i++)
        begin
            @(negedge clk);
            if (done !== 1'b0)
            begin
                $display("done is not low %0d cycles after reset", i);
                errors++;
            end
        end
        issue_same_sign_random(20);
        wait_for_results();
    endtask

    initial
    begin
        void'($urandom(33));
        rst_n = 1'b0;
        start = 1'b0;
        a = 8'h00;
        b = 8'h00;
        c = 8'h00;
        d = 8'h00;
        cycle = 0;
        errors = 0;
        checks = 0;
        apply_reset();
        test_identity();
        test_special_values();
        test_cancellation();
        test_directed_sums();
        test_random_same_sign();
        test_throughput();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: posit_dot2.f
+incdir+dv
source/posit_pkg.sv
source/posit_decode.sv
source/posit_multiply.sv
source/posit_product_adder.sv
source/posit_encode.sv
source/posit_dot2.sv
dv/posit_dot2_tb.sv

// File: source/posit_decode.sv
/*
   Purely combinational. Fields other than nar and zero are meaningless for the
   NaR and zero patterns, missing fraction bits come out as zeros.
*/
`timescale 1ns/1ps
`default_nettype none

module posit_decode (
    input  logic [posit_pkg::POSIT_WIDTH-1:0]        posit,
    output logic                                     sgn,
    output logic signed [posit_pkg::SCALE_WIDTH-1:0] scale,
    output logic [posit_pkg::FRAC_WIDTH-1:0]         fraction,
    output logic                                     nar,
    output logic                                     zero
);
    import posit_pkg::*;

    logic [POSIT_WIDTH-1:0] mag;
    logic [POSIT_WIDTH-2:0] body;
    logic [SCALE_WIDTH-1:0] run;
    logic signed [SCALE_WIDTH-1:0] regime;
    logic [POSIT_WIDTH+FRAC_WIDTH-2:0] tail;
    logic [POSIT_ES-1:0] expo;

    assign sgn = posit[POSIT_WIDTH-1];
    assign nar = (posit == POSIT_NAR);
    assign zero = (posit == '0);

    // Negative posits are decoded from their two's complement
    assign mag = sgn ? -posit : posit;
    assign body = mag[POSIT_WIDTH-2:0];

    // Length of the regime run
    always_comb
    begin : count_run
        logic in_run;
        run = '0;
        in_run = 1'b1;
        for (int i = POSIT_WIDTH - 2; i >= 0; i--)
        begin
            if (in_run && (body[i] == body[POSIT_WIDTH-2]))
                run = run + 1'b1;
            else
                in_run = 1'b0;
        end
    end

    // A run of ones gives run-1, a run of zeros gives -run
    assign regime = body[POSIT_WIDTH-2] ? $signed(run - 1'b1) : -$signed(run);

    // Drop the run and its terminating bit, then exponent and fraction sit on top
    assign tail = {body, {FRAC_WIDTH{1'b0}}} << (run + 1'b1);
    assign expo = tail[POSIT_WIDTH+FRAC_WIDTH-2 -: POSIT_ES];
    assign fraction = tail[POSIT_WIDTH+FRAC_WIDTH-2-POSIT_ES -: FRAC_WIDTH];

    // useed = 16
    assign scale = (regime <<< POSIT_ES) + $signed(SCALE_WIDTH'(expo));

endmodule

`default_nettype wire

// File: source/posit_dot2.sv
/*
   result = a*b + c*d, 11 cycles after start. No back-pressure, so result
   must be taken in the cycle that done is high.
*/
`timescale 1ns/1ps
`default_nettype none

module posit_dot2 (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [posit_pkg::POSIT_WIDTH-1:0] a,
    input  logic [posit_pkg::POSIT_WIDTH-1:0] b,
    input  logic [posit_pkg::POSIT_WIDTH-1:0] c,
    input  logic [posit_pkg::POSIT_WIDTH-1:0] d,
    output logic [posit_pkg::POSIT_WIDTH-1:0] result,
    output logic                              done
);
    import posit_pkg::*;

    logic [PRODUCT_WIDTH-1:0] product_ab, product_cd;
    logic product_done;
    logic [SUM_WIDTH-1:0] sum;
    logic sum_done;
    logic truncated;

    posit_multiply i_mul_ab (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .x            (a),
        .y            (b),
        .product      (product_ab),
        .product_done (product_done)
    );

    // Same latency as i_mul_ab, its strobe would be identical
    posit_multiply i_mul_cd (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .x            (c),
        .y            (d),
        .product      (product_cd),
        .product_done ()
    );

    posit_product_adder i_adder (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (product_done),
        .in1       (product_ab),
        .in2       (product_cd),
        .sum       (sum),
        .done      (sum_done),
        .truncated (truncated)
    );

    posit_encode i_encode (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_done  (sum_done),
        .sum       (sum),
        .truncated (truncated),
        .result    (result),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: source/posit_encode.sv
/*
   Round to nearest even with one cycle of latency. Scales beyond +-24 saturate
   to maxpos or minpos, a nonzero sum never becomes zero or NaR.
*/
`timescale 1ns/1ps
`default_nettype none

module posit_encode (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              sum_done,
    input  logic [posit_pkg::SUM_WIDTH-1:0]   sum,
    input  logic                              truncated,
    output logic [posit_pkg::POSIT_WIDTH-1:0] result,
    output logic                              done
);
    import posit_pkg::*;

    logic sgn, nar, zero;
    logic signed [SCALE_WIDTH-1:0] scale, max_scale, clamped, regime;
    logic [SUM_FRAC_WIDTH-1:0] frac;
    logic neg_regime;
    logic [SCALE_WIDTH-1:0] run_shift;
    logic signed [POSIT_WIDTH+POSIT_ES+SUM_FRAC_WIDTH-1:0] bits;
    logic [POSIT_WIDTH-2:0] body, body_rounded;
    logic guard, sticky, round_up;
    logic [POSIT_WIDTH-1:0] encoded;

    assign sgn = sum[SUM_SGN];
    assign scale = sum[SUM_SCALE_MSB:SUM_SCALE_LSB];
    assign frac = sum[SUM_FRAC_MSB:SUM_FRAC_LSB];
    assign nar = sum[SUM_NAR];
    assign zero = sum[SUM_ZERO];

    // Scale of maxpos, 24 for posit8
    assign max_scale = SCALE_WIDTH'((POSIT_WIDTH - 2) << POSIT_ES);

    assign clamped = (scale > max_scale)  ? max_scale :
                     (scale < -max_scale) ? -max_scale : scale;

    // Floor division, the low bits of the scale are the exponent
    assign regime = clamped >>> POSIT_ES;
    assign neg_regime = regime[SCALE_WIDTH-1];
    assign run_shift = neg_regime ? ~regime : regime;

    // Sign extension of the leading pair builds the regime run
    assign bits = $signed({~neg_regime, neg_regime, clamped[POSIT_ES-1:0], frac,
                           {(POSIT_WIDTH-2){1'b0}}}) >>> run_shift;

    assign body = bits[POSIT_WIDTH+POSIT_ES+SUM_FRAC_WIDTH-1 -: POSIT_WIDTH-1];
    assign guard = bits[POSIT_ES+SUM_FRAC_WIDTH];
    assign sticky = (|bits[POSIT_ES+SUM_FRAC_WIDTH-1:0]) | truncated;
    assign round_up = guard & (sticky | body[0]);

    // maxpos has a zero guard bit, so this cannot overflow into NaR
    assign body_rounded = body + {{(POSIT_WIDTH-2){1'b0}}, round_up};

    assign encoded = nar  ? POSIT_NAR :
                     zero ? '0 :
                     sgn  ? -{1'b0, body_rounded} : {1'b0, body_rounded};

    always_ff @(posedge clk)
    begin
        result <= encoded;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            done <= 1'b0;
        else
            done <= sum_done;
    end

endmodule

`default_nettype wire

// File: source/posit_multiply.sv
/*
   Latency 2 from start to product_done, one operation per cycle.
   NaR takes precedence over zero in the product word.
*/
`timescale 1ns/1ps
`default_nettype none

module posit_multiply (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [posit_pkg::POSIT_WIDTH-1:0]   x,
    input  logic [posit_pkg::POSIT_WIDTH-1:0]   y,
    output logic [posit_pkg::PRODUCT_WIDTH-1:0] product,
    output logic                                product_done
);
    import posit_pkg::*;

    logic x_sgn, x_nar, x_zero;
    logic y_sgn, y_nar, y_zero;
    logic signed [SCALE_WIDTH-1:0] x_scale, y_scale;
    logic [FRAC_WIDTH-1:0] x_frac, y_frac;

    logic s1_start;
    logic s1_x_sgn, s1_x_nar, s1_x_zero;
    logic s1_y_sgn, s1_y_nar, s1_y_zero;
    logic signed [SCALE_WIDTH-1:0] s1_x_scale, s1_y_scale;
    logic [FRAC_WIDTH-1:0] s1_x_frac, s1_y_frac;

    logic [2*FRAC_WIDTH+1:0] sig_prod;
    logic carry;
    logic signed [SCALE_WIDTH-1:0] prod_scale;
    logic [PRODUCT_FRAC_WIDTH-1:0] prod_frac;
    logic prod_nar;

    posit_decode i_decode_x (
        .posit    (x),
        .sgn      (x_sgn),
        .scale    (x_scale),
        .fraction (x_frac),
        .nar      (x_nar),
        .zero     (x_zero)
    );

    posit_decode i_decode_y (
        .posit    (y),
        .sgn      (y_sgn),
        .scale    (y_scale),
        .fraction (y_frac),
        .nar      (y_nar),
        .zero     (y_zero)
    );

    // Stage 1 holds the decoded operands
    always_ff @(posedge clk)
    begin
        s1_x_sgn <= x_sgn;
        s1_x_scale <= x_scale;
        s1_x_frac <= x_frac;
        s1_x_nar <= x_nar;
        s1_x_zero <= x_zero;
        s1_y_sgn <= y_sgn;
        s1_y_scale <= y_scale;
        s1_y_frac <= y_frac;
        s1_y_nar <= y_nar;
        s1_y_zero <= y_zero;
    end

    // Significands lie in [1,2) so the product lies in [1,4)
    assign sig_prod = {1'b1, s1_x_frac} * {1'b1, s1_y_frac};
    assign carry = sig_prod[2*FRAC_WIDTH+1];
    assign prod_scale = s1_x_scale + s1_y_scale + $signed({{(SCALE_WIDTH-1){1'b0}}, carry});
    assign prod_frac = carry ? sig_prod[2*FRAC_WIDTH:0] : {sig_prod[2*FRAC_WIDTH-1:0], 1'b0};
    assign prod_nar = s1_x_nar | s1_y_nar;

    always_ff @(posedge clk)
    begin
        product <= {s1_x_sgn ^ s1_y_sgn, prod_scale, prod_frac, prod_nar,
                    ~prod_nar & (s1_x_zero | s1_y_zero)};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_start <= 1'b0;
            product_done <= 1'b0;
        end
        else
        begin
            s1_start <= start;
            product_done <= s1_start;
        end
    end

    // Every product_done belongs to a start two cycles back
    a_done_after_start : assert property (
        @(posedge clk) disable iff (!rst_n) product_done |-> $past(start, 2)
    ) else $error("product_done without start two cycles earlier");

endmodule

`default_nettype wire

// File: source/posit_pkg.sv
/*
   Posit8 with es = 2 only. Serialized words hold sign, scale, fraction, NaR and zero,
   with the zero flag in bit 0.
*/
`default_nettype none

package posit_pkg;

    localparam int POSIT_WIDTH = 8;
    localparam int POSIT_ES = 2;
    localparam logic [POSIT_WIDTH-1:0] POSIT_NAR = 8'h80;

    // Signed scale of products and sums, -48..+48 plus carry room
    localparam int SCALE_WIDTH = 9;

    // Decoded posit fraction without hidden bit
    localparam int FRAC_WIDTH = 5;

    // Normalized product fraction without hidden bit
    localparam int PRODUCT_FRAC_WIDTH = 11;

    // Adder alignment window: hidden bit, product fraction and three guard bits
    localparam int AMBITS = 15;
    localparam int SUM_FRAC_WIDTH = 15;

    localparam int PRODUCT_WIDTH = 1 + SCALE_WIDTH + PRODUCT_FRAC_WIDTH + 2;
    localparam int SUM_WIDTH = 1 + SCALE_WIDTH + SUM_FRAC_WIDTH + 2;

    // Field positions of the product word
    localparam int PROD_SGN = PRODUCT_WIDTH - 1;
    localparam int PROD_SCALE_MSB = PRODUCT_WIDTH - 2;
    localparam int PROD_SCALE_LSB = PRODUCT_WIDTH - 1 - SCALE_WIDTH;
    localparam int PROD_FRAC_MSB = PROD_SCALE_LSB - 1;
    localparam int PROD_FRAC_LSB = 2;
    localparam int PROD_NAR = 1;
    localparam int PROD_ZERO = 0;

    // Field positions of the sum word
    localparam int SUM_SGN = SUM_WIDTH - 1;
    localparam int SUM_SCALE_MSB = SUM_WIDTH - 2;
    localparam int SUM_SCALE_LSB = SUM_WIDTH - 1 - SCALE_WIDTH;
    localparam int SUM_FRAC_MSB = SUM_SCALE_LSB - 1;
    localparam int SUM_FRAC_LSB = 2;
    localparam int SUM_NAR = 1;
    localparam int SUM_ZERO = 0;

endpackage

`default_nettype wire

// File: source/posit_product_adder.sv
/*
   Latency 8 from start to done. Bits shifted past the 2*AMBITS alignment window
   are lost without sticky. The truncated flag ignores the sign of the lost part.
*/
`timescale 1ns/1ps
`default_nettype none

module posit_product_adder (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic [posit_pkg::PRODUCT_WIDTH-1:0] in1,
    input  logic [posit_pkg::PRODUCT_WIDTH-1:0] in2,
    output logic [posit_pkg::SUM_WIDTH-1:0]     sum,
    output logic                                done,
    output logic                                truncated
);
    import posit_pkg::*;

    logic [7:0] start_pipe;

    logic [PRODUCT_WIDTH-1:0] r0_a, r0_b;
    logic signed [SCALE_WIDTH-1:0] r0_a_scale, r0_b_scale;
    logic [PRODUCT_FRAC_WIDTH-1:0] r0_a_frac, r0_b_frac;
    logic r0_a_first;

    logic [PRODUCT_WIDTH-1:0] r1_hi, r1_lo;
    logic r1_add, r1_nar;
    logic [SCALE_WIDTH-1:0] r1_diff;

    logic [PRODUCT_WIDTH-1:0] r2_hi;
    logic [AMBITS-1:0] r2_lo_sig;
    logic [SCALE_WIDTH-1:0] r2_diff;
    logic r2_add, r2_nar;
    logic [2*AMBITS-1:0] r2_window;

    logic [PRODUCT_WIDTH-1:0] r3_hi;
    logic [AMBITS-1:0] r3_aligned, r3_hi_sig;
    logic r3_sticky, r3_add, r3_nar;
    logic [AMBITS:0] r3_raw;

    logic [AMBITS:0] r4_raw;
    logic r4_sgn, r4_nar, r4_sticky;
    logic signed [SCALE_WIDTH-1:0] r4_scale;
    logic [SCALE_WIDTH-1:0] r4_lz;

    logic [AMBITS:0] r5_raw, r5_norm;
    logic [SCALE_WIDTH-1:0] r5_lz;
    logic signed [SCALE_WIDTH-1:0] r5_scale, r5_scale_norm;
    logic r5_sgn, r5_nar, r5_zero, r5_sticky;

    logic r6_sgn, r6_nar, r6_zero, r6_sticky, r6_clear;
    logic signed [SCALE_WIDTH-1:0] r6_scale;
    logic [SUM_FRAC_WIDTH-1:0] r6_frac;
    logic [SUM_WIDTH-1:0] r6_word;

    // Stage 0 captures the products, a zero word loses its other fields
    always_ff @(posedge clk)
    begin
        r0_a <= in1[PROD_ZERO] ? PRODUCT_WIDTH'(1) : in1;
        r0_b <= in2[PROD_ZERO] ? PRODUCT_WIDTH'(1) : in2;
    end

    assign r0_a_scale = r0_a[PROD_SCALE_MSB:PROD_SCALE_LSB];
    assign r0_b_scale = r0_b[PROD_SCALE_MSB:PROD_SCALE_LSB];
    assign r0_a_frac = r0_a[PROD_FRAC_MSB:PROD_FRAC_LSB];
    assign r0_b_frac = r0_b[PROD_FRAC_MSB:PROD_FRAC_LSB];

    // A goes on top if B is zero or A has the larger magnitude
    assign r0_a_first = r0_b[PROD_ZERO]
                      | (~r0_a[PROD_ZERO] & ((r0_a_scale > r0_b_scale)
                      | ((r0_a_scale == r0_b_scale) & (r0_a_frac >= r0_b_frac))));

    // Stage 1 orders by magnitude
    always_ff @(posedge clk)
    begin
        r1_hi <= r0_a_first ? r0_a : r0_b;
        r1_lo <= r0_a_first ? r0_b : r0_a;
        r1_add <= r0_a[PROD_SGN] ~^ r0_b[PROD_SGN];
        r1_nar <= r0_a[PROD_NAR] | r0_b[PROD_NAR];
    end

    assign r1_diff = r1_hi[PROD_SCALE_MSB:PROD_SCALE_LSB] - r1_lo[PROD_SCALE_MSB:PROD_SCALE_LSB];

    // Stage 2 aligns the smaller significand
    always_ff @(posedge clk)
    begin
        r2_hi <= r1_hi;
        r2_lo_sig <= {~r1_lo[PROD_ZERO], r1_lo[PROD_FRAC_MSB:PROD_FRAC_LSB],
                      {(AMBITS-PRODUCT_FRAC_WIDTH-1){1'b0}}};
        r2_diff <= r1_diff;
        r2_add <= r1_add;
        r2_nar <= r1_nar;
    end

    assign r2_window = {r2_lo_sig, {AMBITS{1'b0}}} >> r2_diff;

    // Stage 3 adds or subtracts
    always_ff @(posedge clk)
    begin
        r3_hi <= r2_hi;
        r3_aligned <= r2_window[2*AMBITS-1:AMBITS];
        r3_sticky <= |r2_window[AMBITS-1:0];
        r3_add <= r2_add;
        r3_nar <= r2_nar;
    end

    assign r3_hi_sig = {~r3_hi[PROD_ZERO], r3_hi[PROD_FRAC_MSB:PROD_FRAC_LSB],
                        {(AMBITS-PRODUCT_FRAC_WIDTH-1){1'b0}}};
    // hi is never smaller than the aligned value, no borrow out
    assign r3_raw = r3_add ? ({1'b0, r3_hi_sig} + {1'b0, r3_aligned})
                           : ({1'b0, r3_hi_sig} - {1'b0, r3_aligned});

    // Stage 4 finds the leading one
    always_ff @(posedge clk)
    begin
        r4_raw <= r3_raw;
        r4_sgn <= r3_hi[PROD_SGN];
        r4_scale <= r3_hi[PROD_SCALE_MSB:PROD_SCALE_LSB];
        r4_nar <= r3_nar;
        r4_sticky <= r3_sticky;
    end

    always_comb
    begin
        r4_lz = '0;
        for (int i = 0; i <= AMBITS; i++)
        begin
            if (r4_raw[i])
                r4_lz = SCALE_WIDTH'(AMBITS - i);
        end
    end

    // Stage 5 normalizes, the hidden bit is shifted out on top
    always_ff @(posedge clk)
    begin
        r5_raw <= r4_raw;
        r5_lz <= r4_lz;
        r5_sgn <= r4_sgn;
        r5_scale <= r4_scale;
        r5_nar <= r4_nar;
        r5_zero <= (r4_raw == '0);
        r5_sticky <= r4_sticky;
    end

    // A carry gives lz = 0 and raises the scale by one
    assign r5_scale_norm = r5_scale - $signed(r5_lz - SCALE_WIDTH'(1));
    assign r5_norm = r5_raw << (r5_lz + 1'b1);

    // Stage 6 assembles the sum word
    always_ff @(posedge clk)
    begin
        r6_sgn <= r5_sgn;
        r6_scale <= r5_scale_norm;
        r6_frac <= r5_norm[AMBITS:1];
        r6_nar <= r5_nar;
        r6_zero <= r5_zero;
        r6_sticky <= r5_sticky;
    end

    // Exact cancellation and zero operands end up here
    assign r6_clear = r6_zero & ~r6_nar;
    assign r6_word = r6_clear ? SUM_WIDTH'(1) : {r6_sgn, r6_scale, r6_frac, r6_nar, 1'b0};

    // Stage 7 drives the outputs
    always_ff @(posedge clk)
    begin
        sum <= r6_word;
        truncated <= r6_sticky & ~r6_clear & ~r6_nar;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            start_pipe <= '0;
        else
            start_pipe <= {start_pipe[6:0], start};
    end

    assign done = start_pipe[7];

    a_done_known : assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(done)
    ) else $error("done is unknown after reset");

endmodule

`default_nettype wire
